//--- verilog/conv_pkg.sv
// geometry, widths and scalar types for the convolution stage
// IMG_W and IMG_H here are only defaults; the top level takes them as parameters
// flattened buses put channel 0 in the least significant slice
`default_nettype none

package conv_pkg;

    // ====================
    // geometry
    // ====================
    localparam int IMG_W  = 6;
    localparam int IMG_H  = 6;
    localparam int KSIZE  = 3;
    localparam int CI     = 2;
    localparam int CO     = 2;

    // ====================
    // widths
    // ====================
    localparam int PIX_BW  = 8;
    localparam int W_BW    = 8;
    localparam int B_BW    = 16;
    // 8+8 product plus 5 bits of growth for 18 terms
    localparam int ACC_BW  = 21;
    localparam int OUT_BW  = 16;
    localparam int PROD_BW = PIX_BW + W_BW;

    // scalar types
    typedef logic signed [PIX_BW-1:0] pix_t;
    typedef logic signed [W_BW-1:0]   weight_t;
    typedef logic signed [B_BW-1:0]   bias_t;
    typedef logic signed [ACC_BW-1:0] acc_t;
    typedef logic        [OUT_BW-1:0] fmap_t;

    // flattened bus widths
    // window order is channel, row, column with the oldest row first
    localparam int WIN_N       = CI * KSIZE * KSIZE;
    localparam int IN_BW       = CI * PIX_BW;
    localparam int WIN_BW      = WIN_N * PIX_BW;
    localparam int CH_WGT_BW   = WIN_N * W_BW;
    // output channel is the outermost weight index
    localparam int WGT_BW      = CO * CH_WGT_BW;
    localparam int BIAS_BUS_BW = CO * B_BW;
    localparam int ACC_BUS_BW  = CO * ACC_BW;
    localparam int OUT_BUS_BW  = CO * OUT_BW;

endpackage

`default_nettype wire

//--- verilog/conv_line_buffer.sv
// raster-order line buffer and 3x3 window builder, stride 1, no padding
// IMG_W and IMG_H must be at least KSIZE; no back-pressure on the input
// window is valid one cycle after the registered pixel that completes it
`timescale 1ns/1ps
`default_nettype none

module conv_line_buffer #(
    parameter int IMG_W = conv_pkg::IMG_W,
    parameter int IMG_H = conv_pkg::IMG_H
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          i_in_valid,
    input  logic [conv_pkg::IN_BW-1:0]    i_in_fmap,
    output logic                          o_win_valid,
    output logic [conv_pkg::WIN_BW-1:0]   o_window
);

    localparam int K      = conv_pkg::KSIZE;
    localparam int CI     = conv_pkg::CI;
    localparam int PIX_BW = conv_pkg::PIX_BW;
    localparam int COL_W  = (IMG_W > 1) ? $clog2(IMG_W) : 1;
    localparam int ROW_W  = (IMG_H > 1) ? $clog2(IMG_H) : 1;

    // ====================
    // input register
    // ====================
    logic                       in_valid_q;
    logic [conv_pkg::IN_BW-1:0] in_pix_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= i_in_valid;
        end
    end

    // pixel payload, held between strobes
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            in_pix_q <= i_in_fmap;
        end
    end

    // ====================
    // position counters
    // ====================
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             win_hit;

    // wrap at frame end so the next frame can follow back to back
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col <= '0;
            row <= '0;
        end else if (in_valid_q) begin
            if (col == COL_W'(IMG_W - 1)) begin
                col <= '0;
                if (row == ROW_W'(IMG_H - 1)) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // current pixel is a window's bottom-right corner
    assign win_hit = in_valid_q && (int'(row) >= K - 1) && (int'(col) >= K - 1);

    // ====================
    // line buffer
    // ====================
    conv_pkg::pix_t line_buf [CI][K][IMG_W];

    // rows move up one slot at this column, new pixel lands in the bottom row
    always_ff @(posedge clk) begin
        if (in_valid_q) begin
            for (int k = 0; k < CI; k++) begin
                for (int j = 0; j < K - 1; j++) begin
                    line_buf[k][j][col] <= line_buf[k][j+1][col];
                end
                line_buf[k][K-1][col] <= conv_pkg::pix_t'(in_pix_q[k*PIX_BW +: PIX_BW]);
            end
        end
    end

    // ====================
    // window register
    // ====================
    // columns left of col are already shifted, column col is not yet
    always_ff @(posedge clk) begin
        int c0;
        c0 = int'(col) - (K - 1);
        if (win_hit) begin
            for (int k = 0; k < CI; k++) begin
                for (int j = 0; j < K; j++) begin
                    for (int i = 0; i < K; i++) begin
                        if (i < K - 1) begin
                            o_window[((k*K + j)*K + i)*PIX_BW +: PIX_BW] <= line_buf[k][j][c0 + i];
                        end else if (j < K - 1) begin
                            o_window[((k*K + j)*K + i)*PIX_BW +: PIX_BW] <= line_buf[k][j+1][col];
                        end else begin
                            // newest pixel straight from the input register
                            o_window[((k*K + j)*K + i)*PIX_BW +: PIX_BW] <=
                                in_pix_q[k*PIX_BW +: PIX_BW];
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_win_valid <= 1'b0;
        end else begin
            o_win_valid <= win_hit;
        end
    end

endmodule

`default_nettype wire

//--- verilog/conv_channel_mac.sv
// dot product of one window with one output channel's weights
// two pipeline stages, one new window accepted every cycle
// weights must stay constant while windows are in flight
`timescale 1ns/1ps
`default_nettype none

module conv_channel_mac (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             i_win_valid,
    input  logic [conv_pkg::WIN_BW-1:0]      i_window,
    input  logic [conv_pkg::CH_WGT_BW-1:0]   i_weight,
    output logic                             o_acc_valid,
    output conv_pkg::acc_t                   o_acc
);

    localparam int N      = conv_pkg::WIN_N;
    localparam int PIX_BW = conv_pkg::PIX_BW;
    localparam int W_BW   = conv_pkg::W_BW;

    logic signed [conv_pkg::PROD_BW-1:0] prod_q [N];
    logic [1:0]                          valid_sr;
    conv_pkg::acc_t                      sum_c;

    // ====================
    // stage 1: products
    // ====================
    always_ff @(posedge clk) begin
        if (i_win_valid) begin
            for (int n = 0; n < N; n++) begin
                prod_q[n] <= conv_pkg::pix_t'(i_window[n*PIX_BW +: PIX_BW]) *
                             conv_pkg::weight_t'(i_weight[n*W_BW +: W_BW]);
            end
        end
    end

    // ====================
    // stage 2: sum
    // ====================
    // sign-extend each product into the accumulator width
    always_comb begin
        sum_c = '0;
        for (int n = 0; n < N; n++) begin
            sum_c = sum_c + conv_pkg::acc_t'(prod_q[n]);
        end
    end

    always_ff @(posedge clk) begin
        if (valid_sr[0]) begin
            o_acc <= sum_c;
        end
    end

    // valid follows the data through both stages
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_sr <= 2'b00;
        end else begin
            valid_sr <= {valid_sr[0], i_win_valid};
        end
    end

    assign o_acc_valid = valid_sr[1];

endmodule

`default_nettype wire

//--- verilog/conv_bias_relu.sv
// bias add, ReLU and saturation to the unsigned output width
// all output channels share one valid strobe
`timescale 1ns/1ps
`default_nettype none

module conv_bias_relu (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              i_acc_valid,
    input  logic [conv_pkg::ACC_BUS_BW-1:0]   i_acc,
    input  logic [conv_pkg::BIAS_BUS_BW-1:0]  i_bias,
    output logic                              o_ot_valid,
    output logic [conv_pkg::OUT_BUS_BW-1:0]   o_ot_fmap
);

    localparam int CO     = conv_pkg::CO;
    localparam int ACC_BW = conv_pkg::ACC_BW;
    localparam int B_BW   = conv_pkg::B_BW;
    localparam int OUT_BW = conv_pkg::OUT_BW;
    // one bit of headroom over the wider operand
    localparam int SUM_BW = ((ACC_BW > B_BW) ? ACC_BW : B_BW) + 1;
    localparam logic signed [SUM_BW-1:0] FMAP_MAX = SUM_BW'((1 << OUT_BW) - 1);

    logic [conv_pkg::OUT_BUS_BW-1:0] fmap_c;

    always_comb begin
        logic signed [SUM_BW-1:0] sum;
        conv_pkg::fmap_t          pt;
        fmap_c = '0;
        for (int c = 0; c < CO; c++) begin
            sum = conv_pkg::acc_t'(i_acc[c*ACC_BW +: ACC_BW]) +
                  conv_pkg::bias_t'(i_bias[c*B_BW +: B_BW]);
            // negative goes to zero, overflow saturates
            if (sum[SUM_BW-1]) begin
                pt = '0;
            end else if (sum > FMAP_MAX) begin
                pt = '1;
            end else begin
                pt = sum[OUT_BW-1:0];
            end
            fmap_c[c*OUT_BW +: OUT_BW] = pt;
        end
    end

    // ====================
    // output register
    // ====================
    always_ff @(posedge clk) begin
        if (i_acc_valid) begin
            o_ot_fmap <= fmap_c;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid <= 1'b0;
        end else begin
            o_ot_valid <= i_acc_valid;
        end
    end

endmodule

`default_nettype wire

//--- verilog/conv_stage_top.sv
// 3x3 convolution stage: line buffer, one MAC per output channel, bias/ReLU
// weights and biases are static levels for the whole frame
// output strobe comes four cycles after the completing pixel's strobe
// no handshake: outputs must be taken when o_ot_valid is high
`timescale 1ns/1ps
`default_nettype none

module conv_stage_top #(
    parameter int IMG_W = conv_pkg::IMG_W,
    parameter int IMG_H = conv_pkg::IMG_H
) (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              i_in_valid,
    input  logic [conv_pkg::IN_BW-1:0]        i_in_fmap,
    input  logic [conv_pkg::WGT_BW-1:0]       i_cnn_weight,
    input  logic [conv_pkg::BIAS_BUS_BW-1:0]  i_cnn_bias,
    output logic                              o_ot_valid,
    output logic [conv_pkg::OUT_BUS_BW-1:0]   o_ot_fmap
);

    localparam int CO        = conv_pkg::CO;
    localparam int ACC_BW    = conv_pkg::ACC_BW;
    localparam int CH_WGT_BW = conv_pkg::CH_WGT_BW;

    logic                              win_valid;
    logic [conv_pkg::WIN_BW-1:0]       window;
    // MACs run in lockstep, bit 0 speaks for all of them
    logic [CO-1:0]                     acc_valid;
    logic [conv_pkg::ACC_BUS_BW-1:0]   acc_bus;

    // ====================
    // window producer
    // ====================
    conv_line_buffer #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_line_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (i_in_valid),
        .i_in_fmap   (i_in_fmap),
        .o_win_valid (win_valid),
        .o_window    (window)
    );

    // ====================
    // per-channel MACs
    // ====================
    for (genvar c = 0; c < CO; c++) begin : g_mac
        conv_channel_mac u_mac (
            .clk         (clk),
            .reset_n     (reset_n),
            .i_win_valid (win_valid),
            .i_window    (window),
            .i_weight    (i_cnn_weight[c*CH_WGT_BW +: CH_WGT_BW]),
            .o_acc_valid (acc_valid[c]),
            .o_acc       (acc_bus[c*ACC_BW +: ACC_BW])
        );
    end

    // bias, ReLU and clamp
    conv_bias_relu u_bias_relu (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_acc_valid (acc_valid[0]),
        .i_acc       (acc_bus),
        .i_bias      (i_cnn_bias),
        .o_ot_valid  (o_ot_valid),
        .o_ot_fmap   (o_ot_fmap)
    );

endmodule

`default_nettype wire

//--- dv/conv_stage_tb.sv
// testbench for conv_stage_top with the default 6x6 geometry
// patterns come from dv/conv_stage_patterns.hex relative to the project root
// frame B loads its weights mid row 1 once frame A has drained
`timescale 1ns/1ps
`default_nettype none

module conv_stage_tb;

    localparam int N_FRAMES    = 2;
    localparam int N_PIX       = conv_pkg::IMG_W * conv_pkg::IMG_H;
    localparam int N_OUT       = (conv_pkg::IMG_W - 2) * (conv_pkg::IMG_H - 2);
    localparam int FRAME_WORDS = 1 + N_PIX + N_OUT;
    localparam int HDR_BW      = conv_pkg::WGT_BW + conv_pkg::BIAS_BUS_BW;
    localparam int LATENCY     = 4;
    localparam int OUT_TIMEOUT = 400;
    localparam int OUT_BW      = conv_pkg::OUT_BW;

    logic                              clk = 1'b0;
    logic                              reset_n;
    logic                              i_in_valid;
    logic [conv_pkg::IN_BW-1:0]        i_in_fmap;
    logic [conv_pkg::WGT_BW-1:0]       i_cnn_weight;
    logic [conv_pkg::BIAS_BUS_BW-1:0]  i_cnn_bias;
    logic                              o_ot_valid;
    logic [conv_pkg::OUT_BUS_BW-1:0]   o_ot_fmap;

    logic [HDR_BW-1:0]                 pat_mem [0:N_FRAMES*FRAME_WORDS-1];
    int                                cyc = 0;
    int                                err_cnt = 0;
    int                                fail_tests = 0;
    int                                last_a_edge = 0;
    // strobe edges of completing pixels in arrival order
    int                                strobe_q [$];
    logic [conv_pkg::OUT_BUS_BW-1:0]   out_fmap_q [$];
    int                                out_time_q [$];
    int                                exp_time_q [$];

    conv_stage_top u_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (i_in_valid),
        .i_in_fmap    (i_in_fmap),
        .i_cnn_weight (i_cnn_weight),
        .i_cnn_bias   (i_cnn_bias),
        .o_ot_valid   (o_ot_valid),
        .o_ot_fmap    (o_ot_fmap)
    );

    always #4 clk = ~clk;

    // cycle index of the last rising edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ====================
    // output monitor
    // ====================
    always @(negedge clk) begin
        if (reset_n && o_ot_valid) begin
            out_fmap_q.push_back(o_ot_fmap);
            out_time_q.push_back(cyc);
            if (strobe_q.size() > 0) begin
                exp_time_q.push_back(strobe_q.pop_front() + LATENCY);
            end else begin
                // no completing pixel to match
                exp_time_q.push_back(-1);
            end
        end
    end

    task automatic check_fmap(input string name, input conv_pkg::fmap_t exp_v,
                              input conv_pkg::fmap_t act_v);
        if (exp_v !== act_v) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic check_latency(input string name, input int exp_v, input int act_v);
        if (exp_v != act_v) begin
            $display("CHECK FAILED %s cycle: expected %0d, actual %0d", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic check_strobe(input string name, input logic exp_v, input logic act_v);
        if (exp_v !== act_v) begin
            $display("CHECK FAILED %s: expected %0b, actual %0b", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, err_cnt - errs_before);
            fail_tests++;
        end
    endtask

    // ====================
    // stimulus
    // ====================
    task automatic drive_frames();
        int idx;
        int gap;
        for (int f = 0; f < N_FRAMES; f++) begin
            for (int p = 0; p < N_PIX; p++) begin
                // later frames wait until the previous frame's last window is done
                if ((f == 0 && p == 0) || (f > 0 && p == 8)) begin
                    idx = f * FRAME_WORDS;
                    i_cnn_weight = pat_mem[idx][conv_pkg::WGT_BW-1:0];
                    i_cnn_bias   = pat_mem[idx][HDR_BW-1:conv_pkg::WGT_BW];
                end
                idx = f * FRAME_WORDS + 1 + p;
                i_in_valid = 1'b1;
                i_in_fmap  = pat_mem[idx][conv_pkg::IN_BW-1:0];
                if (p / conv_pkg::IMG_W >= 2 && p % conv_pkg::IMG_W >= 2) begin
                    strobe_q.push_back(cyc + 1);
                    if (f == 0) begin
                        last_a_edge = cyc + 1;
                    end
                end
                @(negedge clk);
                i_in_valid = 1'b0;
                // gaps only inside a frame so frames run back to back
                if (p < N_PIX - 1) begin
                    gap = int'($urandom % 4);
                    repeat (gap) @(negedge clk);
                end
            end
        end
    endtask

    task automatic check_frame(input string name, input int f, input int first,
                               input int count);
        int               base;
        int               n;
        conv_pkg::fmap_t  exp_v;
        conv_pkg::fmap_t  act_v;
        base = f * FRAME_WORDS + 1 + N_PIX;
        check_count({name, " point count"}, N_OUT, count);
        n = (count < N_OUT) ? count : N_OUT;
        for (int k = 0; k < n; k++) begin
            for (int c = 0; c < conv_pkg::CO; c++) begin
                exp_v = pat_mem[base+k][c*OUT_BW +: OUT_BW];
                act_v = out_fmap_q[first+k][c*OUT_BW +: OUT_BW];
                check_fmap($sformatf("%s point %0d ch %0d", name, k, c), exp_v, act_v);
            end
            if (exp_time_q[first+k] < 0) begin
                $display("ERROR %s point %0d appeared with no completing pixel", name, k);
                err_cnt++;
            end else begin
                check_latency($sformatf("%s point %0d", name, k),
                              exp_time_q[first+k], out_time_q[first+k]);
            end
        end
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        int errs;
        int waited;
        int count_a;
        int count_b;
        reset_n      = 1'b0;
        i_in_valid   = 1'b0;
        i_in_fmap    = '0;
        i_cnn_weight = '0;
        i_cnn_bias   = '0;
        void'($urandom(42));
        $readmemh("dv/conv_stage_patterns.hex", pat_mem);

        repeat (8) @(negedge clk);
        reset_n = 1'b1;

        errs = err_cnt;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_strobe("reset_idle o_ot_valid", 1'b0, o_ot_valid);
        end
        report_test("reset_idle", errs);

        drive_frames();
        waited = 0;
        while (out_fmap_q.size() < N_FRAMES * N_OUT && waited < OUT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        // quiet period catches any extra output points
        repeat (12) @(negedge clk);

        if (out_fmap_q.size() < N_FRAMES * N_OUT) begin
            $display("ERROR timed out waiting for output points, got %0d of %0d",
                     out_fmap_q.size(), N_FRAMES * N_OUT);
            $display("Result: FAILED");
            $finish;
        end else begin
            count_a = 0;
            foreach (out_time_q[i]) begin
                if (out_time_q[i] <= last_a_edge + LATENCY) begin
                    count_a++;
                end
            end
            count_b = out_time_q.size() - count_a;
            errs = err_cnt;
            check_frame("frame_a", 0, 0, count_a);
            report_test("frame_a", errs);
            errs = err_cnt;
            check_frame("frame_b", 1, count_a, count_b);
            check_count("frame_b total points", N_FRAMES * N_OUT, out_fmap_q.size());
            report_test("frame_b", errs);
            $display("tests run 3, tests failed %0d, checks failed %0d", fail_tests, err_cnt);
            if (err_cnt == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- files.f
verilog/conv_pkg.sv
verilog/conv_line_buffer.sv
verilog/conv_channel_mac.sv
verilog/conv_bias_relu.sv
verilog/conv_stage_top.sv
dv/conv_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the convolution stage testbench with Verilator
# run from any directory; paths are relative to the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module conv_stage_tb \
    -o conv_stage_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status, see build.log"
    exit 1
fi

./obj_dir/conv_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see sim.log"
    exit 1
fi

if grep -qx "Result: PASSED" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

//--- dv/conv_stage_patterns.hex
// per frame: header {bias ch1, bias ch0, weights co1, weights co0}, 36 pixels {ch1, ch0},
// then 16 expected outputs {ch1, ch0} in raster order; frame A then frame B
FFF60005030303030303030303010101000000FFFFFF00000000FE00000000010101010101010101
0000
0101
0202
0303
0404
0505
FF06
0007
0108
0209
030A
040B
FE0C
FF0D
000E
010F
0210
0311
FD12
FE13
FF14
0015
0116
0217
FC18
FD19
FE1A
FF1B
001C
011D
FB1E
FC1F
FD20
FE21
FF22
0023
001A0044
0035004B
00500052
006B0059
0000007C
001A0083
0035008A
00500091
000000B4
000000BB
001A00C2
003500C9
000000EC
000000F3
000000FA
001A0101
EC78B1E09C9C9C9C9C9C9C9C9C0000000000000000007F7F7F7F7F7F7F7F7F646464646464646464
CE78
E278
F678
0A78
1E78
3278
CE78
E278
F678
0A78
1E78
3278
CE78
E278
F678
0A78
1E78
3278
CE78
E278
F678
0A78
1E78
3278
CE78
E278
F678
0A78
1E78
3278
CE78
E278
F678
0A78
1E78
3278
55F0D1CE
0FA0FFFF
0000FFFF
0000FFFF
55F0D1CE
0FA0FFFF
0000FFFF
0000FFFF
55F0D1CE
0FA0FFFF
0000FFFF
0000FFFF
55F0D1CE
0FA0FFFF
0000FFFF
0000FFFF
